// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --top-module tb_dcache_top -f sources.f -o tb_dcache_top
./obj_dir/tb_dcache_top | tee "$LOG"

if grep -q "sim failed" "$LOG"; then
    echo "testbench reported a failure, see $LOG"
    exit 1
fi

// ==== sources.f ====
src/dcache_pkg.sv
src/dcache_way_ram.sv
src/dcache_victim_lfsr.sv
src/dcache_line_merge.sv
src/dcache_ctrl.sv
src/dcache_top.sv
test/tb_line_mem.sv
test/tb_dcache_top.sv

// ==== src/dcache_ctrl.sv ====
module dcache_ctrl (
    input  logic                            clk,
    input  logic                            rst,

    // cpu side
    input  logic                            valid_i,
    input  dcache_pkg::addr_t               addr_i,
    input  dcache_pkg::strb_t               wstrb_i,
    input  dcache_pkg::word_t               wdata_i,
    output logic                            ready_o,
    output logic                            data_ok_o,

    // buffered request for the merge unit
    output logic [dcache_pkg::OFFSET_W-1:0] req_offset_o,
    output dcache_pkg::strb_t               req_wstrb_o,
    output dcache_pkg::word_t               req_wdata_o,

    // way rams
    output dcache_pkg::index_t              ram_index_o,
    input  dcache_pkg::tag_t                tag0_rdata_i,
    input  dcache_pkg::tag_t                tag1_rdata_i,
    output logic [dcache_pkg::NWAY-1:0]     tag_we_o,
    output dcache_pkg::tag_t                tag_wdata_o,
    input  dcache_pkg::line_t               data0_rdata_i,
    input  dcache_pkg::line_t               data1_rdata_i,
    output logic [dcache_pkg::NWAY-1:0]     data_we_o,
    output dcache_pkg::line_t               data_wdata_o,
    output dcache_pkg::line_t               hit_line_o,
    input  dcache_pkg::line_t               merged_line_i,
    input  dcache_pkg::way_t                victim_way_i,

    // line memory
    output logic                            mem_req_o,
    output logic                            mem_we_o,
    output dcache_pkg::line_addr_t          mem_addr_o,
    output dcache_pkg::line_t               mem_wdata_o,
    input  logic                            mem_ack_i,
    input  dcache_pkg::line_t               mem_rdata_i
);
    import dcache_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        LOOK_UP,
        WB_REQ,
        WB_DONE,
        RF_REQ,
        RF_DONE
    } state_e;

    state_e state_q;
    state_e state_d;

    addr_t req_addr_q;
    strb_t req_wstrb_q;
    word_t req_wdata_q;
    way_t  victim_q;

    logic [NWAY-1:0][NSET-1:0] valid_q;
    logic [NWAY-1:0][NSET-1:0] dirty_q;

    tag_t             req_tag;
    index_t           req_index;
    logic             is_store;
    tag_t  [NWAY-1:0] way_tag;
    line_t [NWAY-1:0] way_line;
    logic  [NWAY-1:0] way_hit;
    logic             hit;
    way_t             hit_way;
    logic             victim_dirty;

    assign req_tag   = req_addr_q[ADDR_W-1 -: TAG_W];
    assign req_index = req_addr_q[OFFSET_W +: INDEX_W];
    assign is_store  = |req_wstrb_q;

    assign way_tag[0]  = tag0_rdata_i;
    assign way_tag[1]  = tag1_rdata_i;
    assign way_line[0] = data0_rdata_i;
    assign way_line[1] = data1_rdata_i;

    always_comb begin
        way_hit = '0;
        for (int w = 0; w < NWAY; w++) begin
            way_hit[w] = valid_q[w][req_index] && (way_tag[w] == req_tag);
        end
    end

    assign hit     = |way_hit;
    assign hit_way = way_hit[1];

    // decided on the miss cycle, before victim_q is loaded
    assign victim_dirty = valid_q[victim_way_i][req_index] && dirty_q[victim_way_i][req_index];

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (valid_i) begin
                    state_d = LOOK_UP;
                end
            end
            LOOK_UP: begin
                if (hit) begin
                    state_d = IDLE;
                end else if (victim_dirty) begin
                    state_d = WB_REQ;
                end else begin
                    state_d = RF_REQ;
                end
            end
            WB_REQ: begin
                if (mem_ack_i) begin
                    state_d = WB_DONE;
                end
            end
            WB_DONE: begin
                if (!mem_ack_i) begin
                    state_d = RF_REQ;
                end
            end
            RF_REQ: begin
                if (mem_ack_i) begin
                    state_d = RF_DONE;
                end
            end
            RF_DONE: begin
                // look up again, the refilled line now hits
                if (!mem_ack_i) begin
                    state_d = LOOK_UP;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE && valid_i) begin
            req_addr_q  <= addr_i;
            req_wstrb_q <= wstrb_i;
            req_wdata_q <= wdata_i;
        end
        if (state_q == LOOK_UP && !hit) begin
            victim_q <= victim_way_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (state_q == LOOK_UP && hit && is_store) begin
                dirty_q[hit_way][req_index] <= 1'b1;
            end
            if (state_q == RF_REQ && mem_ack_i) begin
                valid_q[victim_q][req_index] <= 1'b1;
                dirty_q[victim_q][req_index] <= is_store;
            end
        end
    end

    // ram writes, and the line fed to the merge unit
    always_comb begin
        tag_we_o   = '0;
        data_we_o  = '0;
        hit_line_o = '0;
        case (state_q)
            LOOK_UP: begin
                if (hit) begin
                    hit_line_o = way_line[hit_way];
                    if (is_store) begin
                        data_we_o[hit_way] = 1'b1;
                    end
                end
            end
            RF_REQ: begin
                if (mem_ack_i) begin
                    hit_line_o          = mem_rdata_i;
                    tag_we_o[victim_q]  = 1'b1;
                    data_we_o[victim_q] = 1'b1;
                end
            end
            default: begin
                hit_line_o = '0;
            end
        endcase
    end

    assign ram_index_o  = (state_q == IDLE) ? addr_i[OFFSET_W +: INDEX_W] : req_index;
    assign tag_wdata_o  = req_tag;
    assign data_wdata_o = merged_line_i;

    assign req_offset_o = req_addr_q[OFFSET_W-1:0];
    assign req_wstrb_o  = req_wstrb_q;
    assign req_wdata_o  = req_wdata_q;

    assign ready_o   = (state_q == IDLE);
    assign data_ok_o = (state_q == LOOK_UP) && hit;

    // rams keep reading req_index, so the victim fields hold steady
    assign mem_req_o   = (state_q == WB_REQ) || (state_q == RF_REQ);
    assign mem_we_o    = (state_q == WB_REQ);
    assign mem_addr_o  = mem_we_o ? {way_tag[victim_q], req_index} : {req_tag, req_index};
    assign mem_wdata_o = way_line[victim_q];

endmodule

// ==== src/dcache_line_merge.sv ====
module dcache_line_merge (
    input  dcache_pkg::line_t                 line_i,
    input  logic [dcache_pkg::OFFSET_W-1:0]   offset_i,
    input  dcache_pkg::strb_t                 wstrb_i,
    input  dcache_pkg::word_t                 wdata_i,
    output dcache_pkg::line_t                 line_o,
    output dcache_pkg::word_t                 word_o
);
    import dcache_pkg::*;

    logic [OFFSET_W-3:0] word_sel;

    // byte bits of the offset do not matter for word access
    assign word_sel = offset_i[OFFSET_W-1:2];

    assign word_o = line_i[word_sel*WORD_W +: WORD_W];

    always_comb begin
        line_o = line_i;
        for (int b = 0; b < WORD_W / 8; b++) begin
            if (wstrb_i[b]) begin
                line_o[word_sel*WORD_W + b*8 +: 8] = wdata_i[b*8 +: 8];
            end
        end
    end

endmodule

// ==== src/dcache_pkg.sv ====
package dcache_pkg;

    // address layout is tag 31..8, index 7..4, offset 3..0
    localparam int ADDR_W         = 32;
    localparam int WORD_W         = 32;
    localparam int LINE_BYTES     = 16;
    localparam int WORDS_PER_LINE = 4;
    localparam int OFFSET_W       = 4;
    localparam int INDEX_W        = 4;
    localparam int TAG_W          = ADDR_W - INDEX_W - OFFSET_W;
    localparam int NSET           = 16;
    localparam int NWAY           = 2;

    // victim selection
    localparam int LFSR_W = 16;
    localparam logic [LFSR_W-1:0] LFSR_SEED = 16'hace1;

    typedef logic [ADDR_W-1:0]           addr_t;
    typedef logic [WORD_W-1:0]           word_t;
    typedef logic [WORD_W/8-1:0]         strb_t;
    typedef logic [LINE_BYTES*8-1:0]     line_t;
    typedef logic [TAG_W-1:0]            tag_t;
    typedef logic [INDEX_W-1:0]          index_t;
    typedef logic [TAG_W+INDEX_W-1:0]    line_addr_t;
    typedef logic                        way_t;

endpackage

// ==== src/dcache_top.sv ====
module dcache_top (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   valid_i,
    input  dcache_pkg::addr_t      addr_i,
    input  dcache_pkg::strb_t      wstrb_i,
    input  dcache_pkg::word_t      wdata_i,
    output logic                   ready_o,
    output logic                   data_ok_o,
    output dcache_pkg::word_t      rdata_o,

    output logic                   mem_req_o,
    output logic                   mem_we_o,
    output dcache_pkg::line_addr_t mem_addr_o,
    output dcache_pkg::line_t      mem_wdata_o,
    input  logic                   mem_ack_i,
    input  dcache_pkg::line_t      mem_rdata_i
);
    import dcache_pkg::*;

    logic [OFFSET_W-1:0] req_offset;
    strb_t               req_wstrb;
    word_t               req_wdata;
    index_t              ram_index;
    tag_t                tag0_rdata;
    tag_t                tag1_rdata;
    logic [NWAY-1:0]     tag_we;
    tag_t                tag_wdata;
    line_t               data0_rdata;
    line_t               data1_rdata;
    logic [NWAY-1:0]     data_we;
    line_t               data_wdata;
    line_t               hit_line;
    line_t               merged_line;
    way_t                victim_way;

    dcache_ctrl i_ctrl (
        .clk           (clk),
        .rst           (rst),
        .valid_i       (valid_i),
        .addr_i        (addr_i),
        .wstrb_i       (wstrb_i),
        .wdata_i       (wdata_i),
        .ready_o       (ready_o),
        .data_ok_o     (data_ok_o),
        .req_offset_o  (req_offset),
        .req_wstrb_o   (req_wstrb),
        .req_wdata_o   (req_wdata),
        .ram_index_o   (ram_index),
        .tag0_rdata_i  (tag0_rdata),
        .tag1_rdata_i  (tag1_rdata),
        .tag_we_o      (tag_we),
        .tag_wdata_o   (tag_wdata),
        .data0_rdata_i (data0_rdata),
        .data1_rdata_i (data1_rdata),
        .data_we_o     (data_we),
        .data_wdata_o  (data_wdata),
        .hit_line_o    (hit_line),
        .merged_line_i (merged_line),
        .victim_way_i  (victim_way),
        .mem_req_o     (mem_req_o),
        .mem_we_o      (mem_we_o),
        .mem_addr_o    (mem_addr_o),
        .mem_wdata_o   (mem_wdata_o),
        .mem_ack_i     (mem_ack_i),
        .mem_rdata_i   (mem_rdata_i)
    );

    dcache_victim_lfsr i_lfsr (
        .clk   (clk),
        .rst   (rst),
        .way_o (victim_way)
    );

    // hit_line is zero outside the response, so word_o is the load data
    dcache_line_merge i_merge (
        .line_i   (hit_line),
        .offset_i (req_offset),
        .wstrb_i  (req_wstrb),
        .wdata_i  (req_wdata),
        .line_o   (merged_line),
        .word_o   (rdata_o)
    );

    dcache_way_ram #(.entry_t(tag_t)) i_tag_ram0 (
        .clk     (clk),
        .addr_i  (ram_index),
        .we_i    (tag_we[0]),
        .wdata_i (tag_wdata),
        .rdata_o (tag0_rdata)
    );

    dcache_way_ram #(.entry_t(tag_t)) i_tag_ram1 (
        .clk     (clk),
        .addr_i  (ram_index),
        .we_i    (tag_we[1]),
        .wdata_i (tag_wdata),
        .rdata_o (tag1_rdata)
    );

    dcache_way_ram #(.entry_t(line_t)) i_data_ram0 (
        .clk     (clk),
        .addr_i  (ram_index),
        .we_i    (data_we[0]),
        .wdata_i (data_wdata),
        .rdata_o (data0_rdata)
    );

    dcache_way_ram #(.entry_t(line_t)) i_data_ram1 (
        .clk     (clk),
        .addr_i  (ram_index),
        .we_i    (data_we[1]),
        .wdata_i (data_wdata),
        .rdata_o (data1_rdata)
    );

endmodule

// ==== src/dcache_victim_lfsr.sv ====
module dcache_victim_lfsr (
    input  logic             clk,
    input  logic             rst,
    output dcache_pkg::way_t way_o
);
    import dcache_pkg::*;

    logic [LFSR_W-1:0] lfsr_q;
    logic              feedback;

    // taps 16,15,13,4 give the maximal period
    assign feedback = lfsr_q[15] ^ lfsr_q[14] ^ lfsr_q[12] ^ lfsr_q[3];

    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr_q <= LFSR_SEED;
        end else begin
            lfsr_q <= {lfsr_q[LFSR_W-2:0], feedback};
        end
    end

    assign way_o = lfsr_q[0];

endmodule

// ==== src/dcache_way_ram.sv ====
module dcache_way_ram #(
    parameter type entry_t = dcache_pkg::line_t
) (
    input  logic               clk,
    input  dcache_pkg::index_t addr_i,
    input  logic               we_i,
    input  entry_t             wdata_i,
    output entry_t             rdata_o
);
    import dcache_pkg::*;

    entry_t mem [NSET];

    // read returns the old entry when written in the same cycle
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[addr_i] <= wdata_i;
        end
        rdata_o <= mem[addr_i];
    end

endmodule

// ==== test/tb_dcache_top.sv ====
module tb_dcache_top;
    timeunit 1ns;
    timeprecision 1ps;
    import dcache_pkg::*;

    localparam int CLK_PERIOD    = 20;
    localparam int RESET_CYCLES  = 3;
    localparam int RAND_SEED     = 70;
    localparam int MAX_ACK_DELAY = 3;
    localparam int RANDOM_OPS    = 250;
    // about 260 requests, two line transfers each, about 10 cycles per transfer
    localparam int TIMEOUT_CYCLES = 12000;

    logic       clk;
    logic       rst;
    logic       valid;
    addr_t      addr;
    strb_t      wstrb;
    word_t      wdata;
    logic       ready;
    logic       data_ok;
    word_t      rdata;
    logic       mem_req;
    logic       mem_we;
    line_addr_t mem_addr;
    line_t      mem_wdata;
    logic       mem_ack;
    line_t      mem_rdata;

    logic [7:0] shadow [addr_t];
    integer     seed;
    int         mismatch_count = 0;
    int         fail_count = 0;
    int         wb_count = 0;
    int         cycle_count = 0;
    int         last_latency;
    bit         last_mem_used;

    dcache_top i_dut (
        .clk         (clk),
        .rst         (rst),
        .valid_i     (valid),
        .addr_i      (addr),
        .wstrb_i     (wstrb),
        .wdata_i     (wdata),
        .ready_o     (ready),
        .data_ok_o   (data_ok),
        .rdata_o     (rdata),
        .mem_req_o   (mem_req),
        .mem_we_o    (mem_we),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata),
        .mem_ack_i   (mem_ack),
        .mem_rdata_i (mem_rdata)
    );

    tb_line_mem #(
        .SEED      (RAND_SEED),
        .MAX_DELAY (MAX_ACK_DELAY)
    ) i_mem (
        .clk         (clk),
        .mem_req_i   (mem_req),
        .mem_we_i    (mem_we),
        .mem_addr_i  (mem_addr),
        .mem_wdata_i (mem_wdata),
        .mem_ack_o   (mem_ack),
        .mem_rdata_o (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
            $display("sim failed");
            $finish;
        end
    end

    // untouched bytes follow the word-address fill of the line memory
    function automatic logic [7:0] shadow_byte(addr_t a);
        word_t init;
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        init = {a[ADDR_W-1:2], 2'b00};
        return init[a[1:0]*8 +: 8];
    endfunction

    function automatic word_t shadow_word(addr_t a);
        word_t w;
        for (int b = 0; b < 4; b++) begin
            w[b*8 +: 8] = shadow_byte({a[ADDR_W-1:2], 2'b00} + addr_t'(b));
        end
        return w;
    endfunction

    function automatic line_t shadow_line(line_addr_t la);
        line_t l;
        for (int i = 0; i < LINE_BYTES; i++) begin
            l[i*8 +: 8] = shadow_byte({la, 4'b0000} + addr_t'(i));
        end
        return l;
    endfunction

    task automatic store_shadow(input addr_t a, input strb_t s, input word_t d);
        for (int b = 0; b < 4; b++) begin
            if (s[b]) begin
                shadow[{a[ADDR_W-1:2], 2'b00} + addr_t'(b)] = d[b*8 +: 8];
            end
        end
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s read %h, expected %h", $time, what, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_line(input line_t got, input line_t exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            mismatch_count++;
        end
    endtask

    // one request, then watch the line port until data_ok
    task automatic run_request(input addr_t a, input strb_t s, input word_t d,
                               output word_t data_out);
        @(posedge clk);
        if (data_ok) begin
            $display("data_ok_o was high at %0t ns with no request outstanding", $time);
            fail_count++;
        end
        valid <= 1'b1;
        addr  <= a;
        wstrb <= s;
        wdata <= d;
        do begin
            @(posedge clk);
        end while (!ready);
        valid <= 1'b0;
        last_latency  = 0;
        last_mem_used = 1'b0;
        do begin
            @(posedge clk);
            last_latency++;
            if (mem_req) begin
                last_mem_used = 1'b1;
            end
            if (mem_req && mem_we && mem_ack) begin
                wb_count++;
                check_line(mem_wdata, shadow_line(mem_addr), "write-back line");
            end
        end while (!data_ok);
        data_out = rdata;
    endtask

    task automatic do_load(input addr_t a, input string what);
        word_t got;
        run_request(a, '0, '0, got);
        check_word(got, shadow_word(a), what);
    endtask

    task automatic do_store(input addr_t a, input strb_t s, input word_t d);
        word_t got;
        run_request(a, s, d, got);
        store_shadow(a, s, d);
    endtask

    task automatic test_reset();
        repeat (5) begin
            @(posedge clk);
            if (ready !== 1'b1 || data_ok !== 1'b0 || mem_req !== 1'b0) begin
                $display("mismatch at %0t ns: idle outputs ready=%b data_ok=%b mem_req=%b",
                         $time, ready, data_ok, mem_req);
                mismatch_count++;
            end
        end
    endtask

    task automatic test_miss_then_hit();
        addr_t a;
        a = 32'h0000_2a48;
        do_load(a, "load miss");
        if (!last_mem_used) begin
            $display("the first load of a line made no memory request");
            fail_count++;
        end
        do_load(a, "load hit");
        if (last_latency != 1) begin
            $display("a load hit took %0d cycles instead of one", last_latency);
            fail_count++;
        end
        if (last_mem_used) begin
            $display("a load hit made a memory request");
            fail_count++;
        end
    endtask

    task automatic test_strobes();
        strb_t strb_list [8] = '{4'b0001, 4'b0100, 4'b0011, 4'b1100,
                                 4'b1111, 4'b1010, 4'b1001, 4'b0110};
        word_t data_list [8] = '{32'hdead_beef, 32'h0123_4567, 32'hcafe_f00d, 32'h89ab_cdef,
                                 32'h5a5a_a5a5, 32'h0f0f_f0f0, 32'h7654_3210, 32'hfeed_face};
        addr_t a;
        a = 32'h0000_3b54;
        for (int i = 0; i < 8; i++) begin
            do_store(a, strb_list[i], data_list[i]);
            do_load(a, $sformatf("load after store with strobe %b", strb_list[i]));
        end
    endtask

    // three tags on one index force a dirty line out of a two-way set
    task automatic test_eviction();
        tag_t  tags [3] = '{24'h000010, 24'h000020, 24'h000030};
        word_t vals [3] = '{32'haaaa_0001, 32'hbbbb_0002, 32'hcccc_0003};
        int    wb_before;
        addr_t a;
        wb_before = wb_count;
        for (int i = 0; i < 3; i++) begin
            a = {tags[i], 4'h5, 4'h4};
            do_store(a, 4'b1111, vals[i]);
        end
        for (int i = 0; i < 3; i++) begin
            a = {tags[i], 4'h5, 4'h4};
            do_load(a, "load after eviction");
        end
        if (wb_count == wb_before) begin
            $display("no write-back was seen while three dirty lines shared one set");
            fail_count++;
        end
    endtask

    task automatic test_random();
        tag_t   tag_pick [4] = '{24'h000041, 24'h000042, 24'h001f00, 24'h7e0000};
        index_t index_pick [4] = '{4'h0, 4'h3, 4'h9, 4'hc};
        integer r;
        addr_t  a;
        strb_t  s;
        word_t  d;
        for (int n = 0; n < RANDOM_OPS; n++) begin
            r = $random(seed);
            a = {tag_pick[r[1:0]], index_pick[r[3:2]], r[5:4], 2'b00};
            d = $random(seed);
            if (r[6]) begin
                s = r[11:8];
                if (s == '0) begin
                    s = 4'b1111;
                end
                do_store(a, s, d);
            end else begin
                do_load(a, "random load");
            end
        end
    endtask

    initial begin
        seed = RAND_SEED;
        rst   <= 1'b1;
        valid <= 1'b0;
        addr  <= '0;
        wstrb <= '0;
        wdata <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        test_reset();
        test_miss_then_hit();
        test_strobes();
        test_eviction();
        test_random();
        repeat (2) @(posedge clk);
        $display("errors: %0d mismatches, %0d other failures, %0d write-backs checked",
                 mismatch_count, fail_count, wb_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== test/tb_line_mem.sv ====
module tb_line_mem #(
    parameter int SEED      = 70,
    parameter int MAX_DELAY = 3
) (
    input  logic                   clk,
    input  logic                   mem_req_i,
    input  logic                   mem_we_i,
    input  dcache_pkg::line_addr_t mem_addr_i,
    input  dcache_pkg::line_t      mem_wdata_i,
    output logic                   mem_ack_o,
    output dcache_pkg::line_t      mem_rdata_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import dcache_pkg::*;

    line_t  lines [line_addr_t];
    integer seed;

    // an unwritten word holds its own byte address
    function automatic line_t read_line(line_addr_t la);
        line_t line;
        addr_t base;
        if (lines.exists(la)) begin
            return lines[la];
        end
        base = {la, 4'b0000};
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            line[w*WORD_W +: WORD_W] = base + addr_t'(w * 4);
        end
        return line;
    endfunction

    function automatic int draw_delay();
        return int'($unsigned($random(seed)) % (MAX_DELAY + 1));
    endfunction

    initial begin
        int delay;
        seed = SEED;
        mem_ack_o   <= 1'b0;
        mem_rdata_o <= '0;
        forever begin
            @(posedge clk);
            if (mem_req_i) begin
                delay = draw_delay();
                repeat (delay) @(posedge clk);
                if (mem_we_i) begin
                    lines[mem_addr_i] = mem_wdata_i;
                end else begin
                    mem_rdata_o <= read_line(mem_addr_i);
                end
                mem_ack_o <= 1'b1;
                // hold ack until the cache drops its request
                do begin
                    @(posedge clk);
                end while (mem_req_i);
                delay = draw_delay();
                repeat (delay) @(posedge clk);
                mem_ack_o <= 1'b0;
            end
        end
    end

endmodule
